// ==== all.f ====
hdl/adc_trigger_pkg.sv
hdl/hit_detector.sv
hdl/sample_pipeline.sv
hdl/acquisition_gate.sv
hdl/adc_trigger_top.sv
verification/adc_trigger_checker.sv
verification/adc_trigger_tb.sv

// ==== hdl/acquisition_gate.sv ====
`timescale 1ns/100ps

module acquisition_gate (
  input  logic                                   CLK,
  input  logic                                   RESET,
  input  logic                                   tvalid,
  input  logic                                   ready,
  input  logic [adc_trigger_pkg::PRE_LEN_BITS-1:0] pre_len,
  input  logic                                   hit_flag,
  input  adc_trigger_pkg::time_t                 current_time,
  input  adc_trigger_pkg::word_t                 pipe_samples,
  input  logic                                   pipe_valid,
  input  adc_trigger_pkg::time_t                 pipe_time,
  output logic                                   triggered,
  output logic                                   out_valid,
  output adc_trigger_pkg::word_t                 out_samples,
  output adc_trigger_pkg::time_t                 out_time,
  output adc_trigger_pkg::time_t                 trig_time
);

  import adc_trigger_pkg::*;

  localparam logic [POST_CNT_BITS-1:0] POST_LAST = POST_CNT_BITS'(POST_LEN - 1);

  // arming state
  logic [PRE_LEN_BITS-1:0] pre_len_q;
  logic [PRE_LEN_BITS-1:0] arm_cnt;
  logic                    armed;
  logic                    enable;

  // trigger window
  logic [POST_CNT_BITS-1:0] post_cnt;
  logic                     post_done;
  logic                     trig_rise;

  // arming length is held from reset
  always_ff @(posedge CLK) begin
    if (RESET) begin
      pre_len_q <= pre_len;
    end
  end

  // a zero length is met by the reset count
  assign armed = (arm_cnt == pre_len_q);

  // consecutive valid words until armed, then frozen
  always_ff @(posedge CLK) begin
    if (RESET) begin
      arm_cnt <= '0;
    end else if (!armed) begin
      if (tvalid) begin
        arm_cnt <= arm_cnt + 1'b1;
      end else begin
        arm_cnt <= '0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      enable <= 1'b0;
    end else begin
      enable <= armed && tvalid && ready;
    end
  end

  assign post_done = (post_cnt == POST_LAST);

  // triggered goes high at this edge
  assign trig_rise = enable && hit_flag && !triggered;

  // window priority: enable, hit, end of window, advance
  always_ff @(posedge CLK) begin
    if (RESET) begin
      triggered <= 1'b0;
      post_cnt  <= '0;
    end else if (!enable) begin
      triggered <= 1'b0;
      post_cnt  <= '0;
    end else if (hit_flag) begin
      triggered <= 1'b1;
      post_cnt  <= '0;
    end else if (post_done) begin
      triggered <= 1'b0;
    end else begin
      post_cnt <= post_cnt + 1'b1;
    end
  end

  // time of the trigger, kept until the next rise
  always_ff @(posedge CLK) begin
    if (RESET) begin
      trig_time <= '0;
    end else if (trig_rise) begin
      trig_time <= current_time;
    end
  end

  // output stage, one cycle behind the pipeline
  always_ff @(posedge CLK) begin
    if (RESET) begin
      out_valid   <= 1'b0;
      out_samples <= '1;
      out_time    <= '0;
    end else begin
      out_valid   <= pipe_valid && triggered;
      out_samples <= pipe_samples;
      out_time    <= pipe_time;
    end
  end

endmodule

// ==== hdl/adc_trigger_pkg.sv ====
package adc_trigger_pkg;

  // converter sample and lane geometry
  localparam int ADC_BITS  = 12;
  localparam int LANE_BITS = 16;
  localparam int LANES     = 8;
  localparam int WORD_BITS = LANES * LANE_BITS;

  // hit rule over adjacent lanes
  localparam int HIT_WINDOW = 2;
  localparam int GROUPS     = LANES / HIT_WINDOW;

  // arming length range
  localparam int PRE_LEN_BITS = 5;

  // trigger window after the last hit, in cycles
  localparam int POST_LEN      = 12;
  localparam int POST_CNT_BITS = 4;

  // free running time value from the system
  localparam int TIME_BITS = 48;

  // signed sample as taken from the top of a lane
  typedef logic signed [ADC_BITS-1:0] sample_t;

  // one bit of growth for sample minus baseline
  typedef logic signed [ADC_BITS:0] delta_t;

  // full stream word, lane 0 in the low bits
  typedef logic [WORD_BITS-1:0] word_t;

  typedef logic [TIME_BITS-1:0] time_t;

endpackage

// ==== hdl/adc_trigger_top.sv ====
`timescale 1ns/100ps

module adc_trigger_top (
  input  logic                                   CLK,
  input  logic                                   RESET,
  // stream from the converter
  input  adc_trigger_pkg::word_t                 tdata,
  input  logic                                   tvalid,
  // downstream level
  input  logic                                   ready,
  // settings, taken during reset
  input  logic [adc_trigger_pkg::PRE_LEN_BITS-1:0] pre_len,
  input  adc_trigger_pkg::delta_t                threshold,
  input  adc_trigger_pkg::sample_t               baseline,
  input  adc_trigger_pkg::time_t                 current_time,
  // gated output
  output logic                                   triggered,
  output logic                                   out_valid,
  output adc_trigger_pkg::word_t                 out_samples,
  output adc_trigger_pkg::time_t                 out_time,
  output adc_trigger_pkg::time_t                 trig_time
);

  import adc_trigger_pkg::*;

  logic  hit_flag;
  word_t pipe_samples;
  logic  pipe_valid;
  time_t pipe_time;

  // hit flag two cycles after the word
  hit_detector u_hit (
    .CLK       (CLK),
    .RESET     (RESET),
    .tdata     (tdata),
    .tvalid    (tvalid),
    .baseline  (baseline),
    .threshold (threshold),
    .hit_flag  (hit_flag)
  );

  // data path matched to the detector
  sample_pipeline u_pipe (
    .CLK          (CLK),
    .RESET        (RESET),
    .tdata        (tdata),
    .tvalid       (tvalid),
    .current_time (current_time),
    .pipe_samples (pipe_samples),
    .pipe_valid   (pipe_valid),
    .pipe_time    (pipe_time)
  );

  acquisition_gate u_gate (
    .CLK          (CLK),
    .RESET        (RESET),
    .tvalid       (tvalid),
    .ready        (ready),
    .pre_len      (pre_len),
    .hit_flag     (hit_flag),
    .current_time (current_time),
    .pipe_samples (pipe_samples),
    .pipe_valid   (pipe_valid),
    .pipe_time    (pipe_time),
    .triggered    (triggered),
    .out_valid    (out_valid),
    .out_samples  (out_samples),
    .out_time     (out_time),
    .trig_time    (trig_time)
  );

endmodule

// ==== hdl/hit_detector.sv ====
`timescale 1ns/100ps

module hit_detector (
  input  logic                     CLK,
  input  logic                     RESET,
  input  adc_trigger_pkg::word_t   tdata,
  input  logic                     tvalid,
  input  adc_trigger_pkg::sample_t baseline,
  input  adc_trigger_pkg::delta_t  threshold,
  output logic                     hit_flag
);

  import adc_trigger_pkg::*;

  // settings held from the reset period
  sample_t baseline_q;
  delta_t  threshold_q;

  // per lane view of the incoming word
  sample_t lane_sample [LANES];
  delta_t  lane_delta [LANES];

  logic [LANES-1:0]  lane_over;
  logic [LANES-1:0]  lane_over_q;
  logic [GROUPS-1:0] group_hit;

  // load settings on every reset cycle, hold afterwards
  always_ff @(posedge CLK) begin
    if (RESET) begin
      baseline_q  <= baseline;
      threshold_q <= threshold;
    end
  end

  // lane compare against threshold
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    // sample sits in the upper bits of the lane
    assign lane_sample[i] = tdata[i*LANE_BITS + LANE_BITS - 1 -: ADC_BITS];

    // sign extend both before subtracting
    assign lane_delta[i] = delta_t'(lane_sample[i]) - delta_t'(baseline_q);

    assign lane_over[i] = (lane_delta[i] >= threshold_q);
  end

  // first stage, dropped when the word is not valid
  always_ff @(posedge CLK) begin
    if (RESET || !tvalid) begin
      lane_over_q <= '0;
    end else begin
      lane_over_q <= lane_over;
    end
  end

  // a group hits only if all its lanes are over
  for (genvar g = 0; g < GROUPS; g++) begin : g_group
    assign group_hit[g] = &lane_over_q[g*HIT_WINDOW +: HIT_WINDOW];
  end

  // second stage, any group is enough
  always_ff @(posedge CLK) begin
    if (RESET) begin
      hit_flag <= 1'b0;
    end else begin
      hit_flag <= |group_hit;
    end
  end

endmodule

// ==== hdl/sample_pipeline.sv ====
`timescale 1ns/100ps

module sample_pipeline (
  input  logic                   CLK,
  input  logic                   RESET,
  input  adc_trigger_pkg::word_t tdata,
  input  logic                   tvalid,
  input  adc_trigger_pkg::time_t current_time,
  output adc_trigger_pkg::word_t pipe_samples,
  output logic                   pipe_valid,
  output adc_trigger_pkg::time_t pipe_time
);

  import adc_trigger_pkg::*;

  // lanes moved down to an unsigned 12-bit field
  word_t lane_fmt;

  // first delay stage
  word_t samples_s1;
  logic  valid_s1;
  time_t time_s1;

  for (genvar i = 0; i < LANES; i++) begin : g_fmt
    // drop the low filler bits and pad the top with zeros
    assign lane_fmt[i*LANE_BITS +: LANE_BITS] = {
      {(LANE_BITS - ADC_BITS){1'b0}},
      tdata[i*LANE_BITS + LANE_BITS - 1 -: ADC_BITS]
    };
  end

  // two stages to line up with the hit detector
  always_ff @(posedge CLK) begin
    if (RESET) begin
      samples_s1 <= '1;
      valid_s1   <= 1'b0;
      time_s1    <= '0;
    end else begin
      samples_s1 <= lane_fmt;
      valid_s1   <= tvalid;
      time_s1    <= current_time;
    end
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      pipe_samples <= '1;
      pipe_valid   <= 1'b0;
      pipe_time    <= '0;
    end else begin
      pipe_samples <= samples_s1;
      pipe_valid   <= valid_s1;
      pipe_time    <= time_s1;
    end
  end

endmodule

// ==== verification/adc_trigger_checker.sv ====
`timescale 1ns/100ps

module adc_trigger_checker (
  input logic CLK,
  input logic RESET,
  input logic hit_flag,
  input logic triggered,
  input logic out_valid
);

  // output words only leave while the window is open
  property out_valid_follows_trigger;
    @(posedge CLK) disable iff (RESET)
      out_valid |-> $past(triggered);
  endproperty

  // a window opens only on a registered hit
  property trigger_rise_needs_hit;
    @(posedge CLK) disable iff (RESET)
      $rose(triggered) |-> $past(hit_flag);
  endproperty

  // control outputs come out of reset low
  property quiet_after_reset;
    @(posedge CLK)
      $fell(RESET) |-> (!out_valid && !triggered);
  endproperty

  a_out_valid_follows_trigger : assert property (out_valid_follows_trigger)
    else $error("out_valid high without triggered on the previous cycle");

  a_trigger_rise_needs_hit : assert property (trigger_rise_needs_hit)
    else $error("triggered rose without hit_flag on the previous cycle");

  a_quiet_after_reset : assert property (quiet_after_reset)
    else $error("out_valid or triggered high in the first cycle after reset");

endmodule

bind acquisition_gate adc_trigger_checker u_checker (
  .CLK       (CLK),
  .RESET     (RESET),
  .hit_flag  (hit_flag),
  .triggered (triggered),
  .out_valid (out_valid)
);

// ==== verification/adc_trigger_tb.sv ====
`timescale 1ns/100ps

module adc_trigger_tb;

  import adc_trigger_pkg::*;

  localparam int PHASE_WORDS    = 1000;
  localparam int TOTAL_WORDS    = 2 * PHASE_WORDS;
  localparam int RESET_CYCLES   = 5;
  localparam int TIMEOUT_CYCLES = TOTAL_WORDS + 2 * RESET_CYCLES + 50;
  localparam logic [31:0] SEED  = 32'hf743_4ee9;

  logic                    CLK;
  logic                    RESET;
  word_t                   tdata;
  logic                    tvalid;
  logic                    ready;
  logic [PRE_LEN_BITS-1:0] pre_len;
  delta_t                  threshold;
  sample_t                 baseline;
  time_t                   current_time;
  logic                    triggered;
  logic                    out_valid;
  word_t                   out_samples;
  time_t                   out_time;
  time_t                   trig_time;

  // stimulus settings of the running phase
  int cur_base;
  int cur_thr;

  int error_count;
  int check_count;
  int rise_count;
  int cycle_count;

  // cycle model state
  int    m_base;
  int    m_thr;
  int    m_pre_len;
  logic  m_hit_s1;
  logic  m_hit;
  word_t m_samp_s1;
  word_t m_samp_s2;
  logic  m_val_s1;
  logic  m_val_s2;
  time_t m_time_s1;
  time_t m_time_s2;
  int    m_arm_cnt;
  logic  m_enable;
  logic  m_trig;
  int    m_post_cnt;
  time_t m_trig_time;
  logic  m_out_valid;
  word_t m_out_samples;
  time_t m_out_time;

  adc_trigger_top dut (
    .CLK          (CLK),
    .RESET        (RESET),
    .tdata        (tdata),
    .tvalid       (tvalid),
    .ready        (ready),
    .pre_len      (pre_len),
    .threshold    (threshold),
    .baseline     (baseline),
    .current_time (current_time),
    .triggered    (triggered),
    .out_valid    (out_valid),
    .out_samples  (out_samples),
    .out_time     (out_time),
    .trig_time    (trig_time)
  );

  initial CLK = 1'b0;
  always #4 CLK = ~CLK;

  // signed sample from the top bits of one lane
  function automatic int lane_value(word_t w, int lane);
    logic signed [ADC_BITS-1:0] s;
    s = w[lane*LANE_BITS + LANE_BITS - 1 -: ADC_BITS];
    return int'(s);
  endfunction

  // true when some full group sits at or over the threshold
  function automatic logic word_hits(word_t w, int base, int thr);
    logic any_group;
    logic all_over;
    any_group = 1'b0;
    for (int g = 0; g < GROUPS; g++) begin
      all_over = 1'b1;
      for (int l = 0; l < HIT_WINDOW; l++) begin
        if (lane_value(w, g*HIT_WINDOW + l) - base < thr) begin
          all_over = 1'b0;
        end
      end
      any_group = any_group | all_over;
    end
    return any_group;
  endfunction

  // each lane becomes its raw 12-bit code with zero padding on top
  function automatic word_t zero_pad_lanes(word_t w);
    word_t r;
    for (int i = 0; i < LANES; i++) begin
      r[i*LANE_BITS +: LANE_BITS] = {4'h0, w[i*LANE_BITS + LANE_BITS - 1 -: ADC_BITS]};
    end
    return r;
  endfunction

  // quiet noise with occasional pulses on one or two lanes
  function automatic word_t make_word(int base, int thr);
    int         delta [LANES];
    int         kind;
    int         pos;
    logic [11:0] code;
    word_t      w;
    for (int i = 0; i < LANES; i++) begin
      delta[i] = int'($urandom_range(thr + 127, 0)) - 128;
    end
    kind = $urandom_range(99, 0);
    if (kind < 6) begin
      // adjacent pair that may straddle two groups
      pos = $urandom_range(LANES - 2, 0);
      delta[pos]     = thr + int'($urandom_range(49, 0));
      delta[pos + 1] = thr + int'($urandom_range(49, 0));
    end else if (kind < 10) begin
      pos = $urandom_range(LANES - 1, 0);
      delta[pos] = thr + int'($urandom_range(80, 0));
    end else if (kind < 13) begin
      // group just under the threshold
      pos = HIT_WINDOW * $urandom_range(GROUPS - 1, 0);
      for (int l = 0; l < HIT_WINDOW; l++) begin
        delta[pos + l] = thr - 1;
      end
      if (kind == 12) begin
        delta[pos] = thr;
      end
    end else if (kind < 15) begin
      pos = HIT_WINDOW * $urandom_range(GROUPS - 1, 0);
      for (int l = 0; l < HIT_WINDOW; l++) begin
        delta[pos + l] = thr;
      end
    end
    for (int i = 0; i < LANES; i++) begin
      code = 12'(base + delta[i]);
      w[i*LANE_BITS +: LANE_BITS] = {code, 4'($urandom_range(15, 0))};
    end
    return w;
  endfunction

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] t=%0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  // called at a falling edge and returns at one
  task automatic apply_reset(input int len, input int base, input int thr);
    RESET     = 1'b1;
    pre_len   = PRE_LEN_BITS'(len);
    baseline  = sample_t'(base);
    threshold = delta_t'(thr);
    tvalid    = 1'b0;
    ready     = 1'b0;
    cur_base  = base;
    cur_thr   = thr;
    repeat (RESET_CYCLES) @(negedge CLK);
    RESET = 1'b0;
  endtask

  task automatic run_words(input int count, input int gap_at);
    for (int n = 0; n < count; n++) begin
      tvalid = (n == gap_at) ? 1'b0 : ($urandom_range(99, 0) >= 5);
      ready  = ($urandom_range(99, 0) >= 3);
      tdata  = make_word(cur_base, cur_thr);
      @(negedge CLK);
    end
  endtask

  // free running time base
  always @(negedge CLK) begin
    current_time <= current_time + 1'b1;
  end

  // model steps from the output end back to the input
  always @(posedge CLK) begin
    logic trig_next;
    logic armed_now;
    if (RESET) begin
      m_base        = int'(baseline);
      m_thr         = int'(threshold);
      m_pre_len     = int'(pre_len);
      m_hit_s1      = 1'b0;
      m_hit         = 1'b0;
      m_samp_s1     = '1;
      m_samp_s2     = '1;
      m_val_s1      = 1'b0;
      m_val_s2      = 1'b0;
      m_time_s1     = '0;
      m_time_s2     = '0;
      m_arm_cnt     = 0;
      m_enable      = 1'b0;
      m_trig        = 1'b0;
      m_post_cnt    = 0;
      m_trig_time   = '0;
      m_out_valid   = 1'b0;
      m_out_samples = '1;
      m_out_time    = '0;
    end else begin
      m_out_valid   = m_val_s2 && m_trig;
      m_out_samples = m_samp_s2;
      m_out_time    = m_time_s2;

      trig_next = m_trig;
      if (!m_enable) begin
        trig_next  = 1'b0;
        m_post_cnt = 0;
      end else if (m_hit) begin
        trig_next  = 1'b1;
        m_post_cnt = 0;
      end else if (m_post_cnt == POST_LEN - 1) begin
        trig_next = 1'b0;
      end else begin
        m_post_cnt++;
      end
      if (trig_next && !m_trig) begin
        m_trig_time = current_time;
        rise_count++;
      end
      m_trig = trig_next;

      armed_now = (m_arm_cnt >= m_pre_len);
      m_enable  = armed_now && tvalid && ready;
      if (!armed_now) begin
        m_arm_cnt = tvalid ? m_arm_cnt + 1 : 0;
      end

      m_hit    = m_hit_s1;
      m_hit_s1 = tvalid && word_hits(tdata, m_base, m_thr);

      m_samp_s2 = m_samp_s1;
      m_val_s2  = m_val_s1;
      m_time_s2 = m_time_s1;
      m_samp_s1 = zero_pad_lanes(tdata);
      m_val_s1  = tvalid;
      m_time_s1 = current_time;
    end
  end

  // outputs are settled half a cycle after the edge
  always @(negedge CLK) begin
    check_value("hit_flag", 128'(m_hit), 128'(dut.hit_flag));
    check_value("triggered", 128'(m_trig), 128'(triggered));
    check_value("out_valid", 128'(m_out_valid), 128'(out_valid));
    check_value("out_samples", m_out_samples, out_samples);
    check_value("out_time", 128'(m_out_time), 128'(out_time));
    check_value("trig_time", 128'(m_trig_time), 128'(trig_time));
  end

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    error_count  = 0;
    check_count  = 0;
    rise_count   = 0;
    cycle_count  = 0;
    tdata        = '0;
    current_time = 48'h0000_1234_0000;
    void'($urandom(SEED));

    // armed after 20 valid words with a gap inside the count
    apply_reset(20, int'($urandom_range(511, 0)) - 256, 200 + int'($urandom_range(255, 0)));
    run_words(PHASE_WORDS, 10);

    // zero arming length arms straight out of reset
    apply_reset(0, int'($urandom_range(511, 0)) - 256, 200 + int'($urandom_range(255, 0)));
    run_words(PHASE_WORDS, -1);

    tvalid = 1'b0;
    repeat (4) @(negedge CLK);
    // let the last falling edge checks complete
    @(posedge CLK);

    if (rise_count == 0) begin
      error_count++;
      $display("no trigger window opened during the whole run");
    end

    $display("checks: %0d, triggers: %0d, errors: %0d", check_count, rise_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
